//--- all.f
+incdir+common
common/backend_pkg.sv
rtl/result_slots.sv
rtl/cdb_arbiter.sv
rob/rob_ptr_counter.sv
rob/reorder_buffer.sv
rtl/register_file.sv
rtl/backend_top.sv
verification/backend_tb.sv

//--- verification/backend_tb.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module backend_tb;

    // upper bound on operations issued by all tests
    localparam int NUM_OPS     = 64;
    localparam int WATCHDOG_NS = (16 + NUM_OPS * 20) * 10;

    logic                  clock;
    logic                  arst_n;
    logic                  dispatch_valid;
    backend_pkg::reg_idx_t dispatch_dest_reg;
    backend_pkg::fu_vec_t  fu_done;
    backend_pkg::rob_tag_t alu_tag;
    backend_pkg::rob_tag_t mult_tag;
    backend_pkg::rob_tag_t btu_tag;
    backend_pkg::xlen_t    alu_value;
    backend_pkg::xlen_t    mult_value;
    backend_pkg::xlen_t    btu_value;
    logic                  btu_mispredict;
    backend_pkg::xlen_t    btu_target;
    backend_pkg::reg_idx_t read_idx;
    backend_pkg::rob_tag_t dispatch_tag;
    logic                  rob_full;
    backend_pkg::fu_vec_t  fu_busy;
    logic                  cdb_valid;
    backend_pkg::rob_tag_t cdb_tag;
    backend_pkg::xlen_t    cdb_value;
    logic                  commit_valid;
    backend_pkg::reg_idx_t commit_reg;
    backend_pkg::xlen_t    commit_data;
    logic                  flush;
    backend_pkg::xlen_t    flush_pc;
    backend_pkg::xlen_t    read_data;

    ///////////////////////////////////////////////////////////////////////
    // reference model state
    ///////////////////////////////////////////////////////////////////////

    // per tag what was dispatched and what its lane will return
    backend_pkg::reg_idx_t exp_dest [`ROB_SIZE];
    backend_pkg::xlen_t    exp_value [`ROB_SIZE];
    logic                  exp_mis [`ROB_SIZE];
    backend_pkg::xlen_t    exp_target [`ROB_SIZE];
    logic                  in_flight [`ROB_SIZE];
    logic                  seen_bcast [`ROB_SIZE];
    // outstanding tags in age order
    backend_pkg::rob_tag_t order_q [$];
    backend_pkg::rob_tag_t exp_tail;
    backend_pkg::xlen_t    shadow_regs [`REG_NUM];
    backend_pkg::reg_idx_t last_commit_reg;
    int                    commit_count;
    int                    flush_count;
    logic [31:0]           lcg_state;

    backend_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ///////////////////////////////////////////////////////////////////////
    // helpers
    ///////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // nonzero destination for random ops
    function automatic backend_pkg::reg_idx_t random_dest();
        return backend_pkg::reg_idx_t'(1 + (lcg_next() % (`REG_NUM - 1)));
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            report_failure($sformatf("MISMATCH %s expected %0h actual %0h",
                                     test_name, expected, actual));
    endtask

    task automatic check_idle(input string phase);
        assert (!commit_valid && !flush && !cdb_valid && !rob_full && fu_busy == '0 &&
                dispatch_tag == '0) else
            report_failure($sformatf("outputs not idle %s", phase));
    endtask

    // one dispatch strobe from falling edge to falling edge
    task automatic dispatch_op(input backend_pkg::reg_idx_t dest, input backend_pkg::xlen_t value,
                               input logic mis, input backend_pkg::xlen_t target);
        assert (!rob_full) else report_failure("rob_full high with fewer than 8 entries");
        check_equal("allocation", exp_tail, dispatch_tag);
        exp_dest[exp_tail]   = dest;
        exp_value[exp_tail]  = value;
        exp_mis[exp_tail]    = mis;
        exp_target[exp_tail] = target;
        in_flight[exp_tail]  = 1'b1;
        seen_bcast[exp_tail] = 1'b0;
        order_q.push_back(exp_tail);
        exp_tail          = exp_tail + 1'b1;
        dispatch_valid    = 1'b1;
        dispatch_dest_reg = dest;
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    // lane fields for one done pulse
    task automatic drive_lane(input int lane, input backend_pkg::rob_tag_t tag);
        fu_done[lane] = 1'b1;
        case (lane)
            `FU_ALU: begin
                alu_tag   = tag;
                alu_value = exp_value[tag];
            end
            `FU_MULT: begin
                mult_tag   = tag;
                mult_value = exp_value[tag];
            end
            default: begin
                btu_tag        = tag;
                btu_value      = exp_value[tag];
                btu_mispredict = exp_mis[tag];
                btu_target     = exp_target[tag];
            end
        endcase
    endtask

    // lane never pulses while its slot is held
    task automatic send_result(input int lane, input backend_pkg::rob_tag_t tag);
        while (fu_busy[lane]) @(negedge clock);
        drive_lane(lane, tag);
        @(negedge clock);
        fu_done = '0;
    endtask

    task automatic wait_drain();
        while (order_q.size() != 0) @(negedge clock);
        while (fu_busy != '0) @(negedge clock);
    endtask

    // shuffle outstanding tags and return them on random lanes
    task automatic finish_in_random_order();
        backend_pkg::rob_tag_t pending [$];
        backend_pkg::rob_tag_t tmp;
        int                    j;
        int                    lane;
        pending = order_q;
        for (int i = pending.size() - 1; i > 0; i--) begin
            j          = int'(lcg_next() % (i + 1));
            tmp        = pending[i];
            pending[i] = pending[j];
            pending[j] = tmp;
        end
        foreach (pending[i]) begin
            lane = int'(lcg_next() % `FU_NUM);
            send_result(lane, pending[i]);
        end
        wait_drain();
    endtask

    ///////////////////////////////////////////////////////////////////////
    // monitor sampling on the rising edge
    ///////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin : bus_monitor
        backend_pkg::rob_tag_t head_tag;
        if (arst_n) begin
            // read port against architectural state before this edge
            check_equal("register_read", shadow_regs[read_idx], read_data);
            if (cdb_valid) begin
                assert (in_flight[cdb_tag]) else
                    report_failure("broadcast of a tag that is not in flight");
                check_equal("cdb_value", exp_value[cdb_tag], cdb_value);
                seen_bcast[cdb_tag] = 1'b1;
            end
            if (commit_valid) begin
                assert (order_q.size() > 0) else
                    report_failure("commit with no entry outstanding");
                head_tag = order_q.pop_front();
                assert (seen_bcast[head_tag]) else
                    report_failure("commit before its result was broadcast");
                check_equal("commit_reg", exp_dest[head_tag], commit_reg);
                check_equal("commit_data", exp_value[head_tag], commit_data);
                check_equal("flush", exp_mis[head_tag], flush);
                if (exp_mis[head_tag]) begin
                    check_equal("flush_pc", exp_target[head_tag], flush_pc);
                end
                in_flight[head_tag] = 1'b0;
                // x0 stays zero
                if (exp_dest[head_tag] != '0) begin
                    shadow_regs[exp_dest[head_tag]] = exp_value[head_tag];
                end
                last_commit_reg = exp_dest[head_tag];
                commit_count++;
                if (flush) begin
                    // younger entries are gone
                    foreach (in_flight[i]) in_flight[i] = 1'b0;
                    order_q.delete();
                    exp_tail = '0;
                    flush_count++;
                end
            end else begin
                assert (!flush) else report_failure("flush without a retiring entry");
            end
        end
    end

    // read back the last retired register
    always @(negedge clock) begin
        read_idx = last_commit_reg;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    ///////////////////////////////////////////////////////////////////////
    // stimulus
    ///////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        backend_pkg::rob_tag_t t0;
        backend_pkg::rob_tag_t t1;
        backend_pkg::rob_tag_t t2;
        backend_pkg::rob_tag_t t3;
        int                    n;
        int                    commits_before;
        lcg_state         = 32'h63ba6918;
        arst_n            = 1'b0;
        dispatch_valid    = 1'b0;
        dispatch_dest_reg = '0;
        fu_done           = '0;
        alu_tag           = '0;
        mult_tag          = '0;
        btu_tag           = '0;
        alu_value         = '0;
        mult_value        = '0;
        btu_value         = '0;
        btu_mispredict    = 1'b0;
        btu_target        = '0;
        read_idx          = '0;
        exp_tail          = '0;
        last_commit_reg   = '0;
        commit_count      = 0;
        flush_count       = 0;
        foreach (shadow_regs[i]) shadow_regs[i] = '0;
        foreach (in_flight[i]) begin
            in_flight[i]  = 1'b0;
            seen_bcast[i] = 1'b0;
        end
        repeat (16) begin
            @(negedge clock);
            check_idle("during reset");
        end
        arst_n = 1'b1;
        @(negedge clock);
        check_idle("after reset");

        // allocation fills to eight then frees one
        for (int i = 0; i < `ROB_SIZE; i++) begin
            dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        end
        assert (rob_full) else report_failure("rob_full low with 8 entries outstanding");
        send_result(`FU_ALU, order_q[0]);
        while (order_q.size() == `ROB_SIZE) @(negedge clock);
        assert (!rob_full) else report_failure("rob_full still high after a commit");
        finish_in_random_order();

        // all three lanes done together give alu then mult then btu
        for (int i = 0; i < 3; i++) begin
            dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        end
        t0 = order_q[0];
        t1 = order_q[1];
        t2 = order_q[2];
        drive_lane(`FU_ALU, t2);
        drive_lane(`FU_MULT, t0);
        drive_lane(`FU_BTU, t1);
        @(negedge clock);
        fu_done = '0;
        check_equal("priority_busy", 3'b111, fu_busy);
        check_equal("priority_tag", t2, cdb_tag);
        @(negedge clock);
        check_equal("priority_busy", 3'b110, fu_busy);
        check_equal("priority_tag", t0, cdb_tag);
        @(negedge clock);
        check_equal("priority_busy", 3'b100, fu_busy);
        check_equal("priority_tag", t1, cdb_tag);
        @(negedge clock);
        check_equal("priority_busy", 3'b000, fu_busy);
        assert (!cdb_valid) else report_failure("bus still driven with no slot held");
        wait_drain();

        // random batches completed out of order
        for (int r = 0; r < 5; r++) begin
            n = 1 + int'(lcg_next() % `ROB_SIZE);
            for (int i = 0; i < n; i++) begin
                dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
            end
            finish_in_random_order();
        end

        // commit to x0 must not show up on the read port
        dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        dispatch_op('0, lcg_next() | 32'h1, 1'b0, '0);
        finish_in_random_order();
        repeat (2) @(negedge clock);

        // mispredicted branch behind one older op and ahead of two younger ones
        dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        dispatch_op(random_dest(), lcg_next(), 1'b1, lcg_next());
        dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        t0 = order_q[0];
        t1 = order_q[1];
        t2 = order_q[2];
        t3 = order_q[3];
        commits_before = commit_count;
        send_result(int'(lcg_next() % `FU_NUM), t0);
        while (commit_count == commits_before) @(negedge clock);
        // branch on the bus, then younger results land in two slots
        drive_lane(`FU_BTU, t1);
        @(negedge clock);
        fu_done = '0;
        // alu wins during the flush cycle and mult is still held at the flush edge
        drive_lane(`FU_ALU, t2);
        drive_lane(`FU_MULT, t3);
        @(negedge clock);
        fu_done = '0;
        while (flush_count == 0) @(negedge clock);
        check_equal("flush_commits", commits_before + 2, commit_count);
        check_equal("flush_tag", 0, dispatch_tag);
        assert (!rob_full && fu_busy == '0) else
            report_failure("rob_full or fu_busy high after flush");
        repeat (4) @(negedge clock);
        check_equal("flush_commits", commits_before + 2, commit_count);
        dispatch_op(random_dest(), lcg_next(), 1'b0, '0);
        finish_in_random_order();
        repeat (4) @(negedge clock);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- rtl/backend_top.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module backend_top (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  dispatch_valid,
    input  backend_pkg::reg_idx_t dispatch_dest_reg,
    input  backend_pkg::fu_vec_t  fu_done,
    input  backend_pkg::rob_tag_t alu_tag,
    input  backend_pkg::rob_tag_t mult_tag,
    input  backend_pkg::rob_tag_t btu_tag,
    input  backend_pkg::xlen_t    alu_value,
    input  backend_pkg::xlen_t    mult_value,
    input  backend_pkg::xlen_t    btu_value,
    input  logic                  btu_mispredict,
    input  backend_pkg::xlen_t    btu_target,
    input  backend_pkg::reg_idx_t read_idx,
    output backend_pkg::rob_tag_t dispatch_tag,
    output logic                  rob_full,
    output backend_pkg::fu_vec_t  fu_busy,
    output logic                  cdb_valid,
    output backend_pkg::rob_tag_t cdb_tag,
    output backend_pkg::xlen_t    cdb_value,
    output logic                  commit_valid,
    output backend_pkg::reg_idx_t commit_reg,
    output backend_pkg::xlen_t    commit_data,
    output logic                  flush,
    output backend_pkg::xlen_t    flush_pc,
    output backend_pkg::xlen_t    read_data
);

    ///////////////////////////////////////////////////////////////////////
    // holding slots and bus
    ///////////////////////////////////////////////////////////////////////

    backend_pkg::fu_vec_t                slot_ready;
    backend_pkg::rob_tag_t [`FU_NUM-1:0] slot_tag;
    backend_pkg::xlen_t [`FU_NUM-1:0]    slot_value;
    logic                                slot_mispredict;
    backend_pkg::xlen_t                  slot_target;
    backend_pkg::fu_vec_t                grant;
    // rob only
    logic                                cdb_mispredict;
    backend_pkg::xlen_t                  cdb_target;

    // a held result keeps its lane busy
    assign fu_busy = slot_ready;

    result_slots i_result_slots (
        .clock           (clock),
        .arst_n          (arst_n),
        .flush           (flush),
        .fu_done         (fu_done),
        .alu_tag         (alu_tag),
        .mult_tag        (mult_tag),
        .btu_tag         (btu_tag),
        .alu_value       (alu_value),
        .mult_value      (mult_value),
        .btu_value       (btu_value),
        .btu_mispredict  (btu_mispredict),
        .btu_target      (btu_target),
        .grant           (grant),
        .slot_ready      (slot_ready),
        .slot_tag        (slot_tag),
        .slot_value      (slot_value),
        .slot_mispredict (slot_mispredict),
        .slot_target     (slot_target)
    );

    cdb_arbiter i_cdb_arbiter (
        .slot_ready      (slot_ready),
        .slot_tag        (slot_tag),
        .slot_value      (slot_value),
        .slot_mispredict (slot_mispredict),
        .slot_target     (slot_target),
        .grant           (grant),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_mispredict  (cdb_mispredict),
        .cdb_target      (cdb_target)
    );

    ///////////////////////////////////////////////////////////////////////
    // retire path
    ///////////////////////////////////////////////////////////////////////

    reorder_buffer i_reorder_buffer (
        .clock             (clock),
        .arst_n            (arst_n),
        .dispatch_valid    (dispatch_valid),
        .dispatch_dest_reg (dispatch_dest_reg),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_value         (cdb_value),
        .cdb_mispredict    (cdb_mispredict),
        .cdb_target        (cdb_target),
        .dispatch_tag      (dispatch_tag),
        .rob_full          (rob_full),
        .commit_valid      (commit_valid),
        .commit_reg        (commit_reg),
        .commit_data       (commit_data),
        .flush             (flush),
        .flush_pc          (flush_pc)
    );

    register_file i_register_file (
        .clock        (clock),
        .arst_n       (arst_n),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .read_idx     (read_idx),
        .read_data    (read_data)
    );

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module register_file (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  commit_valid,
    input  backend_pkg::reg_idx_t commit_reg,
    input  backend_pkg::xlen_t    commit_data,
    input  backend_pkg::reg_idx_t read_idx,
    output backend_pkg::xlen_t    read_data
);

    // architectural state
    backend_pkg::xlen_t regs [`REG_NUM];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && (commit_reg != '0)) begin
            // x0 is never written
            regs[commit_reg] <= commit_data;
        end
    end

    // x0 hardwired to zero
    assign read_data = (read_idx == '0) ? '0 : regs[read_idx];

endmodule

//--- rob/reorder_buffer.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module reorder_buffer (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  dispatch_valid,
    input  backend_pkg::reg_idx_t dispatch_dest_reg,
    input  logic                  cdb_valid,
    input  backend_pkg::rob_tag_t cdb_tag,
    input  backend_pkg::xlen_t    cdb_value,
    input  logic                  cdb_mispredict,
    input  backend_pkg::xlen_t    cdb_target,
    output backend_pkg::rob_tag_t dispatch_tag,
    output logic                  rob_full,
    output logic                  commit_valid,
    output backend_pkg::reg_idx_t commit_reg,
    output backend_pkg::xlen_t    commit_data,
    output logic                  flush,
    output backend_pkg::xlen_t    flush_pc
);

    ///////////////////////////////////////////////////////////////////////
    // entry storage
    ///////////////////////////////////////////////////////////////////////

    // per entry status
    logic [`ROB_SIZE-1:0]  entry_valid;
    logic [`ROB_SIZE-1:0]  entry_complete;
    logic [`ROB_SIZE-1:0]  entry_mispredict;
    // per entry payload
    backend_pkg::reg_idx_t entry_dest [`ROB_SIZE];
    backend_pkg::xlen_t    entry_value [`ROB_SIZE];
    backend_pkg::xlen_t    entry_target [`ROB_SIZE];

    // pointer side
    backend_pkg::rob_tag_t head;
    backend_pkg::rob_tag_t tail;
    logic                  rob_empty;
    logic                  push;
    logic                  pop;

    // dispatch accepted only with room left
    assign push = dispatch_valid & ~rob_full;

    // tag handed out is the next tail slot
    assign dispatch_tag = tail;

    rob_ptr_counter i_rob_ptr_counter (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (push),
        .pop       (pop),
        .flush     (flush),
        .head      (head),
        .tail      (tail),
        .rob_full  (rob_full),
        .rob_empty (rob_empty)
    );

    ///////////////////////////////////////////////////////////////////////
    // retire from head
    ///////////////////////////////////////////////////////////////////////

    // oldest entry done, retire it now
    assign commit_valid = ~rob_empty & entry_valid[head] & entry_complete[head];
    assign commit_reg   = entry_dest[head];
    assign commit_data  = entry_value[head];
    assign pop          = commit_valid;

    // mispredicted branch at retire redirects the front end
    assign flush    = commit_valid & entry_mispredict[head];
    assign flush_pc = entry_target[head];

    // status bits
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid    <= '0;
            entry_complete <= '0;
        end else if (flush) begin
            // younger entries never retire
            entry_valid    <= '0;
            entry_complete <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
            end
            if (push) begin
                entry_valid[tail]    <= 1'b1;
                entry_complete[tail] <= 1'b0;
            end
            // broadcast marks its entry done
            if (cdb_valid && entry_valid[cdb_tag]) begin
                entry_complete[cdb_tag] <= 1'b1;
            end
        end
    end

    // payload written at dispatch and at broadcast
    always_ff @(posedge clock) begin
        if (push) begin
            entry_dest[tail] <= dispatch_dest_reg;
        end
        if (cdb_valid) begin
            entry_value[cdb_tag]      <= cdb_value;
            entry_mispredict[cdb_tag] <= cdb_mispredict;
            entry_target[cdb_tag]     <= cdb_target;
        end
    end

endmodule

//--- rob/rob_ptr_counter.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module rob_ptr_counter (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  push,
    input  logic                  pop,
    input  logic                  flush,
    output backend_pkg::rob_tag_t head,
    output backend_pkg::rob_tag_t tail,
    output logic                  rob_full,
    output logic                  rob_empty
);

    // entries in flight
    backend_pkg::rob_cnt_t count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // everything in flight is dropped
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap at ROB_SIZE by width
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // push with pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rob_full  = (count == backend_pkg::rob_cnt_t'(`ROB_SIZE));
    assign rob_empty = (count == '0);

endmodule

//--- rtl/cdb_arbiter.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module cdb_arbiter (
    input  backend_pkg::fu_vec_t                slot_ready,
    input  backend_pkg::rob_tag_t [`FU_NUM-1:0] slot_tag,
    input  backend_pkg::xlen_t [`FU_NUM-1:0]    slot_value,
    input  logic                                slot_mispredict,
    input  backend_pkg::xlen_t                  slot_target,
    output backend_pkg::fu_vec_t                grant,
    output logic                                cdb_valid,
    output backend_pkg::rob_tag_t               cdb_tag,
    output backend_pkg::xlen_t                  cdb_value,
    output logic                                cdb_mispredict,
    output backend_pkg::xlen_t                  cdb_target
);

    // lowest set bit of ready, so alu > mult > btu
    assign grant = slot_ready & (~slot_ready + 1'b1);

    // any ready slot drives the bus
    assign cdb_valid = |slot_ready;

    // one-hot mux of the granted slot
    always_comb begin
        cdb_tag   = '0;
        cdb_value = '0;
        for (int i = 0; i < `FU_NUM; i++) begin
            if (grant[i]) begin
                cdb_tag   = slot_tag[i];
                cdb_value = slot_value[i];
            end
        end
    end

    // btu fields count only when btu owns the bus
    assign cdb_mispredict = grant[`FU_BTU] & slot_mispredict;
    assign cdb_target     = slot_target;

endmodule

//--- rtl/result_slots.sv
`timescale 1ns/100ps

`include "backend_defines.svh"

module result_slots (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                flush,
    input  backend_pkg::fu_vec_t                fu_done,
    input  backend_pkg::rob_tag_t               alu_tag,
    input  backend_pkg::rob_tag_t               mult_tag,
    input  backend_pkg::rob_tag_t               btu_tag,
    input  backend_pkg::xlen_t                  alu_value,
    input  backend_pkg::xlen_t                  mult_value,
    input  backend_pkg::xlen_t                  btu_value,
    input  logic                                btu_mispredict,
    input  backend_pkg::xlen_t                  btu_target,
    input  backend_pkg::fu_vec_t                grant,
    output backend_pkg::fu_vec_t                slot_ready,
    output backend_pkg::rob_tag_t [`FU_NUM-1:0] slot_tag,
    output backend_pkg::xlen_t [`FU_NUM-1:0]    slot_value,
    output logic                                slot_mispredict,
    output backend_pkg::xlen_t                  slot_target
);

    // lane inputs gathered by lane index
    backend_pkg::rob_tag_t [`FU_NUM-1:0] lane_tag;
    backend_pkg::xlen_t [`FU_NUM-1:0]    lane_value;
    // lanes whose done is taken this cycle
    backend_pkg::fu_vec_t                accept;

    assign lane_tag[`FU_ALU]    = alu_tag;
    assign lane_tag[`FU_MULT]   = mult_tag;
    assign lane_tag[`FU_BTU]    = btu_tag;
    assign lane_value[`FU_ALU]  = alu_value;
    assign lane_value[`FU_MULT] = mult_value;
    assign lane_value[`FU_BTU]  = btu_value;

    // slot free, or emptied by the bus this cycle
    // a done into a held slot that loses the bus is lost
    assign accept = fu_done & (~slot_ready | grant);

    ///////////////////////////////////////////////////////////////////////
    // ready bits
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slot_ready <= '0;
        end else if (flush) begin
            // mispredict wipes all pending results
            slot_ready <= '0;
        end else begin
            // new result sets, grant clears, otherwise hold
            slot_ready <= accept | (slot_ready & ~grant);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // held results
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < `FU_NUM; i++) begin
            if (accept[i]) begin
                slot_tag[i]   <= lane_tag[i];
                slot_value[i] <= lane_value[i];
            end
        end
        // branch outcome only exists on the btu lane
        if (accept[`FU_BTU]) begin
            slot_mispredict <= btu_mispredict;
            slot_target     <= btu_target;
        end
    end

endmodule

//--- common/backend_pkg.sv
`include "backend_defines.svh"

package backend_pkg;

    ///////////////////////////////////////////////////////////////////////
    // data path types
    ///////////////////////////////////////////////////////////////////////

    // data word or pc
    typedef logic [`XLEN-1:0] xlen_t;

    // architectural register index
    typedef logic [`REG_ADDR_LEN-1:0] reg_idx_t;

    ///////////////////////////////////////////////////////////////////////
    // reorder buffer and lane types
    ///////////////////////////////////////////////////////////////////////

    // rob entry tag
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

    // occupancy, one bit wider than a tag to hold 0..ROB_SIZE
    typedef logic [`ROB_TAG_LEN:0] rob_cnt_t;

    // one bit per lane: done, busy, grant
    typedef logic [`FU_NUM-1:0] fu_vec_t;

endpackage

//--- common/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// data path and pc width
`define XLEN 32

// reorder buffer depth, power of two so the pointers wrap on their own
`define ROB_SIZE 8
`define ROB_TAG_LEN 3

// architectural register file
`define REG_NUM 32
`define REG_ADDR_LEN 5

// result lanes
`define FU_NUM 3

// lane indices, lower index wins the bus
`define FU_ALU 0
`define FU_MULT 1
`define FU_BTU 2

`endif
